// ==== fir_pkg.sv ====
/*
 * shared widths, tap counts and pipeline latency of the symmetric FIR
 * sample and coefficient types, folded coefficient table
 */
`default_nettype none

package fir_pkg;

	// sample, partial sum and product width
	localparam int SAMPLE_WIDTH = 18;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
	typedef logic signed [SAMPLE_WIDTH-1:0] coeff_t;

	// filter length and number of folded taps
	localparam int TAP_COUNT          = 44;
	localparam int UNIQUE_COEFF_COUNT = TAP_COUNT / 2;

	// enabled edges from sample capture to o_out
	localparam int PIPELINE_LATENCY = 8;

	// coefficient k weights taps k and TAP_COUNT-1-k
	localparam coeff_t COEFFICIENTS [UNIQUE_COEFF_COUNT] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0,
		18'sd212,
		18'sd451,
		18'sd710,
		18'sd980,
		18'sd1252,
		18'sd1514,
		18'sd1756,
		18'sd1971
	};

endpackage

`default_nettype wire

// ==== fir_tap_delay_line.sv ====
/*
 * sample delay line of the FIR, 44 enabled stages with async clear
 * taps are handed out already folded as near/far pairs
 */
`timescale 1ns/10ps
`default_nettype none

module fir_tap_delay_line (
	input  wire              clk,
	input  wire              reset,
	input  wire              i_clk_ena,
	input  wire fir_pkg::sample_t i_in,
	output fir_pkg::sample_t o_near_taps [fir_pkg::UNIQUE_COEFF_COUNT],
	output fir_pkg::sample_t o_far_taps  [fir_pkg::UNIQUE_COEFF_COUNT]
);
	import fir_pkg::*;

	// tap 0 holds the newest sample
	sample_t taps [TAP_COUNT];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < TAP_COUNT; i++) begin
				taps[i] <= '0;
			end
		end else if (i_clk_ena) begin
			taps[0] <= i_in;
			for (int i = 1; i < TAP_COUNT; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// mirror the upper half onto the lower
	for (genvar k = 0; k < UNIQUE_COEFF_COUNT; k++) begin : g_fold
		assign o_near_taps[k] = taps[k];
		assign o_far_taps[k]  = taps[TAP_COUNT-1-k];
	end

endmodule

`default_nettype wire

// ==== fir_tap_products.sv ====
/*
 * folded pre-adders and coefficient multipliers of the FIR
 * two register stages, all arithmetic wraps at 18 bits
 */
`timescale 1ns/10ps
`default_nettype none

module fir_tap_products (
	input  wire              clk,
	input  wire              i_clk_ena,
	input  wire fir_pkg::sample_t i_near_taps [fir_pkg::UNIQUE_COEFF_COUNT],
	input  wire fir_pkg::sample_t i_far_taps  [fir_pkg::UNIQUE_COEFF_COUNT],
	output fir_pkg::sample_t o_products  [fir_pkg::UNIQUE_COEFF_COUNT]
);
	import fir_pkg::*;

	// tap k plus tap 43-k
	sample_t pair_sum [UNIQUE_COEFF_COUNT];

	//**********************************************************************
	// stage 1, pre-add
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < UNIQUE_COEFF_COUNT; k++) begin
				pair_sum[k] <= i_near_taps[k] + i_far_taps[k];
			end
		end
	end

	//**********************************************************************
	// stage 2, multiply
	//**********************************************************************

	// only the low 18 bits of each product are kept
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < UNIQUE_COEFF_COUNT; k++) begin
				o_products[k] <= pair_sum[k] * COEFFICIENTS[k];
			end
		end
	end

endmodule

`default_nettype wire

// ==== fir_adder_tree.sv ====
/*
 * registered binary adder tree, 22 products down to one sum
 * five levels, bye registers keep odd leftovers aligned
 */
`timescale 1ns/10ps
`default_nettype none

module fir_adder_tree (
	input  wire              clk,
	input  wire              i_clk_ena,
	input  wire fir_pkg::sample_t i_products [fir_pkg::UNIQUE_COEFF_COUNT],
	output fir_pkg::sample_t o_sum
);
	import fir_pkg::*;

	// partial sums per level
	sample_t level1 [11];
	sample_t level2 [6];
	sample_t level3 [3];
	sample_t level4 [2];

	//**********************************************************************
	// level 1, 22 -> 11
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int i = 0; i < UNIQUE_COEFF_COUNT / 2; i++) begin
				level1[i] <= i_products[2*i] + i_products[2*i+1];
			end
		end
	end

	//**********************************************************************
	// level 2, 11 -> 6
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int i = 0; i < 5; i++) begin
				level2[i] <= level1[2*i] + level1[2*i+1];
			end
			// bye for the odd one out
			level2[5] <= level1[10];
		end
	end

	//**********************************************************************
	// level 3, 6 -> 3
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int i = 0; i < 3; i++) begin
				level3[i] <= level2[2*i] + level2[2*i+1];
			end
		end
	end

	//**********************************************************************
	// level 4, 3 -> 2
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			level4[0] <= level3[0] + level3[1];
			// bye, waits one level for its partner
			level4[1] <= level3[2];
		end
	end

	//**********************************************************************
	// level 5, final sum
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			o_sum <= level4[0] + level4[1];
		end
	end

endmodule

`default_nettype wire

// ==== fir_valid_delay.sv ====
/*
 * valid flag pipeline of the FIR, as deep as the data path
 */
`timescale 1ns/10ps
`default_nettype none

module fir_valid_delay (
	input  wire  clk,
	input  wire  reset,
	input  wire  i_clk_ena,
	input  wire  i_valid,
	output logic o_valid
);
	import fir_pkg::*;

	// bit 0 takes the flag of the sample entering tap 0
	logic [PIPELINE_LATENCY-1:0] valid_pipe;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_pipe <= '0;
		end else if (i_clk_ena) begin
			valid_pipe <= {valid_pipe[PIPELINE_LATENCY-2:0], i_valid};
		end
	end

	// lines up with o_sum of the adder tree
	assign o_valid = valid_pipe[PIPELINE_LATENCY-1];

endmodule

`default_nettype wire

// ==== fir_top.sv ====
/*
 * top level of the 44-tap symmetric FIR filter
 * delay line, folded products, adder tree and valid delay
 */
`timescale 1ns/10ps
`default_nettype none

module fir_top (
	input  wire              clk,
	input  wire              reset,
	input  wire              i_clk_ena,
	input  wire              i_valid,
	input  wire fir_pkg::sample_t i_in,
	output logic             o_valid,
	output fir_pkg::sample_t o_out
);
	import fir_pkg::*;

	// folded tap pairs, near k goes with far 43-k
	sample_t near_taps [UNIQUE_COEFF_COUNT];
	sample_t far_taps  [UNIQUE_COEFF_COUNT];

	// coefficient-weighted pair sums
	sample_t products  [UNIQUE_COEFF_COUNT];

	//**********************************************************************
	// data path
	//**********************************************************************

	fir_tap_delay_line fir_tap_delay_line_inst (
		.clk         (clk),
		.reset       (reset),
		.i_clk_ena   (i_clk_ena),
		.i_in        (i_in),
		.o_near_taps (near_taps),
		.o_far_taps  (far_taps)
	);

	// pre-add then multiply, two stages
	fir_tap_products fir_tap_products_inst (
		.clk         (clk),
		.i_clk_ena   (i_clk_ena),
		.i_near_taps (near_taps),
		.i_far_taps  (far_taps),
		.o_products  (products)
	);

	// five registered levels down to one sum
	fir_adder_tree fir_adder_tree_inst (
		.clk        (clk),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_out)
	);

	//**********************************************************************
	// valid flag
	//**********************************************************************

	// same depth as the data path
	fir_valid_delay fir_valid_delay_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

// ==== fir_tb_properties.sv ====
/*
 * concurrent assertions bound to fir_top
 * reset, stall hold and valid flag rules
 */
`timescale 1ns/10ps
`default_nettype none

module fir_tb_properties (
	input wire              clk,
	input wire              reset,
	input wire              i_clk_ena,
	input wire              o_valid,
	input wire fir_pkg::sample_t o_out
);
	import fir_pkg::*;

	int failure_count = 0;

	// cleared asynchronously, so low at every edge while held
	valid_low_in_reset: assert property (@(posedge clk) reset |-> !o_valid)
		else begin
			failure_count++;
			$error("o_valid high while reset is asserted");
		end

	// disabled edge freezes the outputs
	outputs_hold_in_stall: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(o_out) && $stable(o_valid))
		else begin
			failure_count++;
			$error("o_out or o_valid changed on an edge with i_clk_ena low");
		end

	valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(o_valid))
		else begin
			failure_count++;
			$error("o_valid unknown after reset");
		end

endmodule

bind fir_top fir_tb_properties fir_tb_properties_inst (
	.clk       (clk),
	.reset     (reset),
	.i_clk_ena (i_clk_ena),
	.o_valid   (o_valid),
	.o_out     (o_out)
);

`default_nettype wire

// ==== fir_tb.sv ====
/*
 * testbench of the symmetric FIR, clock, reset, LCG stimulus
 * sample history model, check task and the test sequence
 */
`timescale 1ns/10ps
`default_nettype none

module fir_tb;
	import fir_pkg::*;

	localparam int DRAIN_LIMIT = 64;

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	// model state
	logic [31:0] seed;
	sample_t     hist [TAP_COUNT];
	sample_t     exp_q [$];
	sample_t     got_q [$];
	logic        vin_q [$];
	logic        vout_q [$];
	int          in_count;
	int          out_count;
	sample_t     prev_out;
	logic        prev_valid;
	string       test_name;

	fir_top fir_top_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//**********************************************************************
	// helpers
	//**********************************************************************

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic sample_t rand_sample();
		logic [31:0] r;
		r = next_rand();
		return sample_t'(r[30:13]);
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = next_rand();
		return r[24];
	endfunction

	// symmetric sum over the sample history, wrapped to 18 bits
	function automatic sample_t model_output();
		longint acc;
		acc = 0;
		for (int k = 0; k < UNIQUE_COEFF_COUNT; k++) begin
			acc += longint'(COEFFICIENTS[k]) *
				(longint'(hist[k]) + longint'(hist[TAP_COUNT-1-k]));
		end
		return sample_t'(acc[SAMPLE_WIDTH-1:0]);
	endfunction

	function automatic int first_high(input logic flags [$]);
		for (int i = 0; i < flags.size(); i++) begin
			if (flags[i] === 1'b1) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR: test %s expected %0d actual %0d", name, expected, actual);
			stop_with_failure("value mismatch");
		end
	endtask

	// outputs seen right after the edge that used ena, vld and din
	task automatic observe(input logic ena, input logic vld, input sample_t din);
		if (reset) begin
			check({test_name, " o_valid in reset"}, 0, o_valid);
		end else if (!ena) begin
			check({test_name, " stall o_out"}, prev_out, o_out);
			check({test_name, " stall o_valid"}, prev_valid, o_valid);
		end else begin
			for (int i = TAP_COUNT - 1; i > 0; i--) begin
				hist[i] = hist[i-1];
			end
			hist[0] = din;
			vin_q.push_back(vld);
			vout_q.push_back(o_valid);
			if (o_valid) begin
				if (exp_q.size() == 0) begin
					stop_with_failure({test_name, ": o_valid high with no sample pending"});
				end
				check({test_name, " o_out"}, exp_q.pop_front(), o_out);
				got_q.push_back(o_out);
				out_count++;
			end
			if (vld) begin
				exp_q.push_back(model_output());
				in_count++;
			end
		end
		prev_out   = o_out;
		prev_valid = o_valid;
	endtask

	// called just after a rising edge
	task automatic drive(input logic ena, input logic vld, input sample_t din);
		i_clk_ena = ena;
		i_valid   = vld;
		i_in      = din;
		@(posedge clk);
		#1;
		observe(ena, vld, din);
	endtask

	task automatic reset_dut(input int cycles);
		reset = 1'b1;
		for (int i = 0; i < TAP_COUNT; i++) begin
			hist[i] = '0;
		end
		exp_q.delete();
		got_q.delete();
		vin_q.delete();
		vout_q.delete();
		in_count  = 0;
		out_count = 0;
		repeat (cycles) drive(1'b1, 1'b0, '0);
		reset = 1'b0;
	endtask

	task automatic drain();
		int guard;
		for (guard = 0; exp_q.size() != 0; guard++) begin
			if (guard == DRAIN_LIMIT) begin
				stop_with_failure({test_name, ": timeout waiting for pending outputs"});
			end
			drive(1'b1, 1'b0, '0);
		end
	endtask

	//**********************************************************************
	// tests
	//**********************************************************************

	task automatic impulse_response();
		test_name = "impulse_response";
		reset_dut(4);
		drive(1'b1, 1'b1, 18'sd1);
		repeat (TAP_COUNT - 1) drive(1'b1, 1'b1, '0);
		repeat (PIPELINE_LATENCY) drive(1'b1, 1'b0, '0);
		check({test_name, " output count"}, TAP_COUNT, got_q.size());
		// rising half then the mirror image
		for (int j = 0; j < TAP_COUNT; j++) begin
			if (j < UNIQUE_COEFF_COUNT) begin
				check({test_name, " tap"}, COEFFICIENTS[j], got_q[j]);
			end else begin
				check({test_name, " tap"}, COEFFICIENTS[TAP_COUNT-1-j], got_q[j]);
			end
		end
	endtask

	task automatic random_stream();
		int f;
		int g;
		test_name = "random_stream";
		reset_dut(4);
		repeat (3) drive(1'b1, 1'b0, rand_sample());
		repeat (100) drive(1'b1, 1'b1, rand_sample());
		drain();
		f = first_high(vin_q);
		g = first_high(vout_q);
		if (f < 0 || g < 0) begin
			stop_with_failure("random_stream: o_valid never rose");
		end
		// capture edge counts as the first
		check({test_name, " first valid latency"}, PIPELINE_LATENCY, g - f + 1);
	endtask

	task automatic valid_pattern();
		test_name = "valid_pattern";
		reset_dut(4);
		repeat (150) drive(1'b1, rand_bit(), rand_sample());
		repeat (PIPELINE_LATENCY) drive(1'b1, 1'b0, '0);
		check({test_name, " valid count"}, in_count, out_count);
		for (int i = 0; i < vout_q.size(); i++) begin
			if (i < PIPELINE_LATENCY - 1) begin
				check({test_name, " o_valid"}, 0, vout_q[i]);
			end else begin
				check({test_name, " o_valid"}, vin_q[i-PIPELINE_LATENCY+1], vout_q[i]);
			end
		end
	endtask

	task automatic stall_phases();
		logic [31:0] r;
		int          stall_len;
		test_name = "stall_phases";
		for (int n = 0; n < 200; n++) begin
			r = next_rand();
			if (r[17:16] == 2'd0) begin
				stall_len = 1 + (r[23:20] % 5);
				// inputs wander while frozen
				repeat (stall_len) drive(1'b0, rand_bit(), rand_sample());
			end
			drive(1'b1, rand_bit(), rand_sample());
		end
		drain();
	endtask

	task automatic wraparound_stream();
		logic [31:0] r;
		sample_t     s;
		test_name = "wraparound_stream";
		for (int n = 0; n < 120; n++) begin
			r = next_rand();
			case (r[19:18])
				2'd0: s = 18'sd131071;
				2'd1: s = -18'sd131072;
				2'd2: s = -18'sd1;
				default: s = rand_sample();
			endcase
			drive(1'b1, 1'b1, s);
		end
		drain();
	endtask

	task automatic mid_stream_reset();
		test_name = "mid_stream_reset";
		repeat (30) drive(1'b1, 1'b1, rand_sample());
		// pending results are lost with the reset
		reset_dut(3);
		check({test_name, " o_valid after reset"}, 0, o_valid);
		repeat (20) drive(1'b1, 1'b1, '0);
		repeat (PIPELINE_LATENCY) drive(1'b1, 1'b0, '0);
		check({test_name, " output count"}, 20, got_q.size());
		for (int i = 0; i < got_q.size(); i++) begin
			check({test_name, " zero output"}, 0, got_q[i]);
		end
	endtask

	//**********************************************************************
	// sequence
	//**********************************************************************

	initial begin
		seed      = 32'd13186;
		reset     = 1'b1;
		i_clk_ena = 1'b0;
		i_valid   = 1'b0;
		i_in      = '0;
		test_name = "power_on_reset";
		reset_dut(16);
		impulse_response();
		random_stream();
		valid_pattern();
		stall_phases();
		wraparound_stream();
		mid_stream_reset();
		if (fir_top_inst.fir_tb_properties_inst.failure_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_with_failure("a bound assertion on fir_top failed");
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
fir_pkg.sv
fir_tap_delay_line.sv
fir_tap_products.sv
fir_adder_tree.sv
fir_valid_delay.sv
fir_top.sv
fir_tb_properties.sv
fir_tb.sv
